// ==== hw/button_decoder.sv ====
`default_nettype none
`include "letter_cycler_cfg.svh"

module button_decoder #(
    parameter int DEBOUNCE_CYCLES = `LC_DEBOUNCE_DEFAULT
) (
    input  wire                              clk,
    input  wire                              rst_n,
    input  wire                              btn_up,
    input  wire                              btn_down,
    input  wire                              btn_left,
    input  wire                              btn_right,
    input  wire                              btn_center,
    input  wire                              new_round,
    output letter_cycler_pkg::button_cmd_t   cmd,
    output logic                             check_held
);
    import letter_cycler_pkg::*;

    localparam int CNT_W = $clog2(DEBOUNCE_CYCLES + 1);

    logic [3:0]       btn_now;   // Index 0 is up, 3 is right
    logic [3:0]       btn_prev;
    logic [3:0]       win;       // One-hot winner of this edge
    logic             blank;
    logic [CNT_W-1:0] cnt [4];

    assign btn_now    = {btn_right, btn_left, btn_down, btn_up};
    assign blank      = (cmd != CMD_NONE) && (cmd != CMD_CHECK);  // Cycle after a move
    assign check_held = btn_center;

    // Lowest index wins, which gives up, down, left, right
    always_comb begin
        win = '0;
        for (int i = 0; i < 4; i++) begin
            if (btn_now[i] && !btn_prev[i] && cnt[i] == '0 && !blank && win == '0) begin
                win[i] = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            btn_prev <= '0;
            cmd      <= CMD_NONE;
        end else begin
            btn_prev <= btn_now;
            if (new_round)                 cmd <= CMD_NONE;
            else if (win[0])               cmd <= CMD_UP;
            else if (win[1])               cmd <= CMD_DOWN;
            else if (win[2])               cmd <= CMD_LEFT;
            else if (win[3])               cmd <= CMD_RIGHT;
            else if (btn_center && !blank) cmd <= CMD_CHECK;  // Repeats while held
            else                           cmd <= CMD_NONE;
        end
    end

    // Release debounce, a held button never counts down
    for (genvar i = 0; i < 4; i++) begin : g_debounce
        always_ff @(posedge clk or negedge rst_n) begin
            if (!rst_n) begin
                cnt[i] <= '0;
            end else if (new_round) begin
                cnt[i] <= '0;
            end else if (win[i]) begin
                cnt[i] <= CNT_W'(DEBOUNCE_CYCLES);
            end else if (!btn_now[i] && cnt[i] != '0) begin
                cnt[i] <= cnt[i] - 1'b1;
            end
        end
    end

    a_no_back_to_back_move: assert property (@(posedge clk) disable iff (!rst_n)
        blank |=> !blank);

endmodule

`default_nettype wire

// ==== hw/glyph_rom.sv ====
`default_nettype none
`include "letter_cycler_cfg.svh"

module glyph_rom (
    input  wire letter_cycler_pkg::letter_t letter,
    input  wire [3:0]                       row,
    input  wire [3:0]                       col,
    output logic                            lit
);
    logic [99:0] bitmap;   // Row-major, MSB is top left
    logic [6:0]  bit_idx;

    always_comb begin
        case (letter)
        5'd0:  bitmap = {50'b0011111100_0011111100_0111001110_0110000110_0110000110,  // A
                         50'b0111111110_0111111110_0110000110_0110000110_0110000110};
        5'd1:  bitmap = {50'b0111111000_0111111100_0110001110_0110001110_0111111110,
                         50'b0111111100_0110001110_0110001110_0111111110_0111111100};
        5'd2:  bitmap = {50'b0011111100_0111111110_0110000010_0110000000_0110000000,
                         50'b0110000000_0110000000_0110000010_0111111110_0011111100};
        5'd3:  bitmap = {50'b0111111000_0111111100_0110001110_0110000110_0110000110,
                         50'b0110000110_0110000110_0110001110_0111111100_0111111000};
        5'd4:  bitmap = {50'b0111111110_0111111110_0110000000_0110000000_0111111000,  // E
                         50'b0111111000_0110000000_0110000000_0111111110_0111111110};
        5'd5:  bitmap = {50'b0111111110_0111111110_0110000000_0110000000_0111111000,
                         50'b0111111000_0110000000_0110000000_0110000000_0110000000};
        5'd6:  bitmap = {50'b0011111100_0111111110_0110000010_0110000000_0110000000,
                         50'b0110011110_0110011110_0110000110_0111111110_0011111100};
        5'd7:  bitmap = {50'b0110000110_0110000110_0110000110_0111111110_0111111110,
                         50'b0110000110_0110000110_0110000110_0110000110_0110000110};
        5'd8:  bitmap = {50'b0111111110_0111111110_0000110000_0000110000_0000110000,  // I
                         50'b0000110000_0000110000_0000110000_0111111110_0111111110};
        5'd9:  bitmap = {50'b0111111110_0111111110_0000011000_0000011000_0000011000,
                         50'b0000011000_0110011000_0110011000_0111111000_0011111000};
        5'd10: bitmap = {50'b0110001110_0110011100_0110111000_0111100000_0111100000,
                         50'b0111110000_0110111000_0110011100_0110001110_0110001110};
        5'd11: bitmap = {50'b0110000000_0110000000_0110000000_0110000000_0110000000,
                         50'b0110000000_0110000000_0110000000_0111111110_0111111110};
        5'd12: bitmap = {50'b0110000110_0111001110_0111111110_0111111110_0111111110,
                         50'b0110110110_0110000110_0110000110_0110000110_0110000110};
        5'd13: bitmap = {50'b0110000110_0111000110_0111100110_0111110110_0111111110,  // N
                         50'b0110111110_0110011110_0110001110_0110000110_0110000110};
        5'd14: bitmap = {50'b0011111100_0111111110_0110000110_0110000110_0110000110,
                         50'b0110000110_0110000110_0110000110_0111111110_0011111100};
        5'd15: bitmap = {50'b0111111100_0111111110_0110000110_0110000110_0111111110,
                         50'b0111111100_0110000000_0110000000_0110000000_0110000000};
        5'd16: bitmap = {50'b0011111100_0111111110_0110000110_0110000110_0110000110,
                         50'b0110000110_0110001110_0111111110_0011111110_0000000010};
        5'd17: bitmap = {50'b0111111100_0111111110_0110000110_0110000110_0111111110,  // R
                         50'b0111111100_0110111000_0110011100_0110001110_0110000110};
        5'd18: bitmap = {50'b0011111100_0111111110_0110000110_0110000000_0011111100,
                         50'b0001111110_0000000110_0110000110_0111111110_0011111100};
        5'd19: bitmap = {50'b0111111110_0111111110_0000110000_0000110000_0000110000,
                         50'b0000110000_0000110000_0000110000_0000110000_0000110000};
        5'd20: bitmap = {50'b0110000110_0110000110_0110000110_0110000110_0110000110,
                         50'b0110000110_0110000110_0110000110_0111111110_0011111100};
        5'd21: bitmap = {50'b0110000110_0110000110_0110000110_0110000110_0110000110,  // V
                         50'b0110000110_0011001100_0011001100_0001111000_0000110000};
        5'd22: bitmap = {50'b0110000110_0110000110_0110000110_0110000110_0110110110,
                         50'b0111111110_0111111110_0111111110_0111001110_0110000110};
        5'd23: bitmap = {50'b0110000110_0110000110_0011001100_0001111000_0001111000,
                         50'b0011001100_0110000110_0110000110_0110000110_0110000110};
        5'd24: bitmap = {50'b0110000110_0110000110_0011001100_0011111100_0001111000,
                         50'b0000110000_0000110000_0000110000_0000110000_0000110000};
        5'd25: bitmap = {50'b0111111110_0111111110_0000001110_0000011100_0000111000,  // Z
                         50'b0001110000_0011100000_0111000000_0111111110_0111111110};
        default: bitmap = '0;  // Blank for codes past Z
        endcase
    end

    assign bit_idx = 7'(row * `LC_GLYPH_SIZE + col);
    assign lit     = (row < `LC_GLYPH_SIZE && col < `LC_GLYPH_SIZE) ? bitmap[99 - bit_idx] : 1'b0;

endmodule

`default_nettype wire

// ==== hw/letter_cycler.sv ====
`default_nettype none
`include "letter_cycler_cfg.svh"

module letter_cycler #(
    parameter int DEBOUNCE_CYCLES = `LC_DEBOUNCE_DEFAULT
) (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             btn_up,
    input  wire                             btn_down,
    input  wire                             btn_left,
    input  wire                             btn_right,
    input  wire                             btn_center,
    input  wire                             new_round,
    input  wire [12:0]                      pixel_idx,
    input  wire letter_cycler_pkg::letter_t target [`LC_NUM_SLOTS],
    input  wire [2:0]                       hint_level,
    input  wire                             hint_active,
    output letter_cycler_pkg::rgb565_t      oled_data,
    output logic                            word_correct
);
    import letter_cycler_pkg::*;

    button_cmd_t cmd;
    logic        check_held;
    letter_t     word [`LC_NUM_SLOTS];
    slot_t       sel;
    slot_mask_t  locked;

    button_decoder #(
        .DEBOUNCE_CYCLES (DEBOUNCE_CYCLES)
    ) i_button_decoder (
        .clk        (clk),
        .rst_n      (rst_n),
        .btn_up     (btn_up),
        .btn_down   (btn_down),
        .btn_left   (btn_left),
        .btn_right  (btn_right),
        .btn_center (btn_center),
        .new_round  (new_round),
        .cmd        (cmd),
        .check_held (check_held)
    );

    word_editor i_word_editor (
        .clk         (clk),
        .rst_n       (rst_n),
        .new_round   (new_round),
        .cmd         (cmd),
        .target      (target),
        .hint_level  (hint_level),
        .hint_active (hint_active),
        .word        (word),
        .sel         (sel),
        .locked      (locked),
        .correct     (word_correct)
    );

    oled_renderer i_oled_renderer (
        .pixel_idx  (pixel_idx),
        .word       (word),
        .sel        (sel),
        .locked     (locked),
        .correct    (word_correct),
        .check_held (check_held),
        .oled_data  (oled_data)
    );

endmodule

`default_nettype wire

// ==== hw/letter_cycler_cfg.svh ====
`ifndef LETTER_CYCLER_CFG_SVH
`define LETTER_CYCLER_CFG_SVH

// Alphabet and word size
`define LC_NUM_LETTERS       26
`define LC_NUM_SLOTS         5

// Letter row geometry, slot i starts at LC_LETTER_X0 + 13 * i
`define LC_GLYPH_SIZE        10
`define LC_SPACING           3
`define LC_LETTER_X0         17
`define LC_LETTER_Y          27
`define LC_UNDERLINE_Y       39

// Panel and border ring
`define LC_OLED_W            96
`define LC_OLED_H            64
`define LC_BORDER_OFFSET     3
`define LC_BORDER_WIDTH      2

// RGB565 colours
`define LC_COL_WHITE         16'hFFFF
`define LC_COL_BLACK         16'h0000
`define LC_COL_GREEN         16'h07E0
`define LC_COL_RED           16'hF800
`define LC_COL_BLUE          16'h001F
`define LC_COL_YELLOW        16'hFFE0

`define LC_DEBOUNCE_DEFAULT  1250000   // Release time in clocks

`endif

// ==== hw/letter_cycler_pkg.sv ====
`default_nettype none

package letter_cycler_pkg;

    typedef logic [4:0]  letter_t;     // 0 is A, 25 is Z
    typedef logic [2:0]  slot_t;       // Word position 0 to 4
    typedef logic [4:0]  slot_mask_t;  // Bit i for slot i
    typedef logic [15:0] rgb565_t;     // R5 G6 B5

    // One-cycle commands from the button decoder
    typedef enum logic [2:0] {
        CMD_NONE  = 3'd0,
        CMD_UP    = 3'd1,
        CMD_DOWN  = 3'd2,
        CMD_LEFT  = 3'd3,
        CMD_RIGHT = 3'd4,
        CMD_CHECK = 3'd5
    } button_cmd_t;

endpackage

`default_nettype wire

// ==== hw/oled_renderer.sv ====
`default_nettype none
`include "letter_cycler_cfg.svh"

module oled_renderer (
    input  wire [12:0]                         pixel_idx,
    input  wire letter_cycler_pkg::letter_t    word [`LC_NUM_SLOTS],
    input  wire letter_cycler_pkg::slot_t      sel,
    input  wire letter_cycler_pkg::slot_mask_t locked,
    input  wire                                correct,
    input  wire                                check_held,
    output letter_cycler_pkg::rgb565_t         oled_data
);
    import letter_cycler_pkg::*;

    localparam int STEP = `LC_GLYPH_SIZE + `LC_SPACING;   // Slot pitch
    localparam int B0   = `LC_BORDER_OFFSET;
    localparam int B1   = `LC_BORDER_OFFSET + `LC_BORDER_WIDTH;

    logic [6:0] x;
    logic [5:0] y;
    logic       hit;        // Pixel lies in a slot box
    slot_t      hit_slot;
    logic [3:0] glyph_row;
    logic [3:0] glyph_col;
    logic       lit;
    logic       in_ring;
    logic [6:0] sel_x0;
    logic       on_underline;

    assign x = 7'(pixel_idx % `LC_OLED_W);
    assign y = 6'(pixel_idx / `LC_OLED_W);

    ////////////////////////////////////////////////////////////////////////////
    // Geometry

    always_comb begin
        hit       = 1'b0;
        hit_slot  = '0;
        glyph_row = '0;
        glyph_col = '0;
        for (int i = 0; i < `LC_NUM_SLOTS; i++) begin
            if (x >= `LC_LETTER_X0 + STEP * i && x < `LC_LETTER_X0 + STEP * i + `LC_GLYPH_SIZE
                && y >= `LC_LETTER_Y && y < `LC_LETTER_Y + `LC_GLYPH_SIZE) begin
                hit       = 1'b1;
                hit_slot  = slot_t'(i);
                glyph_col = 4'(x - (`LC_LETTER_X0 + STEP * i));
                glyph_row = 4'(y - `LC_LETTER_Y);
            end
        end
    end

    glyph_rom i_glyph_rom (
        .letter (word[hit_slot]),
        .row    (glyph_row),
        .col    (glyph_col),
        .lit    (lit)
    );

    // Ring is the outer box minus the inner box
    assign in_ring = (x >= B0 && x < `LC_OLED_W - B0 && y >= B0 && y < `LC_OLED_H - B0)
                  && !(x >= B1 && x < `LC_OLED_W - B1 && y >= B1 && y < `LC_OLED_H - B1);

    assign sel_x0       = 7'(`LC_LETTER_X0 + STEP * sel);
    assign on_underline = (y == `LC_UNDERLINE_Y) && (x >= sel_x0)
                       && (x < sel_x0 + `LC_GLYPH_SIZE) && !locked[sel] && !correct;

    ////////////////////////////////////////////////////////////////////////////
    // Layers in paint order

    always_comb begin
        oled_data = `LC_COL_BLACK;
        if (in_ring) oled_data = `LC_COL_BLUE;
        if (hit && lit) begin
            if (correct)               oled_data = `LC_COL_GREEN;
            else if (check_held)       oled_data = `LC_COL_RED;
            else if (locked[hit_slot]) oled_data = `LC_COL_YELLOW;
            else                       oled_data = `LC_COL_WHITE;
        end
        if (on_underline) oled_data = check_held ? `LC_COL_RED : `LC_COL_WHITE;
    end

    // Glyph pixel must sit in the box of its own slot, found by pitch arithmetic
    a_letter_in_box: assert final (!(hit && lit)
        || (x >= `LC_LETTER_X0
            && (x - `LC_LETTER_X0) % STEP < `LC_GLYPH_SIZE
            && (x - `LC_LETTER_X0) / STEP == hit_slot
            && y >= `LC_LETTER_Y && y < `LC_LETTER_Y + `LC_GLYPH_SIZE));

endmodule

`default_nettype wire

// ==== hw/word_editor.sv ====
`default_nettype none
`include "letter_cycler_cfg.svh"

module word_editor (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 new_round,
    input  wire letter_cycler_pkg::button_cmd_t cmd,
    input  wire letter_cycler_pkg::letter_t     target [`LC_NUM_SLOTS],
    input  wire [2:0]                           hint_level,
    input  wire                                 hint_active,
    output letter_cycler_pkg::letter_t          word [`LC_NUM_SLOTS],
    output letter_cycler_pkg::slot_t            sel,
    output letter_cycler_pkg::slot_mask_t       locked,
    output logic                                correct
);
    import letter_cycler_pkg::*;

    localparam int      NS   = `LC_NUM_SLOTS;
    localparam letter_t LAST = letter_t'(`LC_NUM_LETTERS - 1);

    slot_mask_t hint_mask;
    slot_t      left_sel;
    slot_t      right_sel;
    slot_t      skip_sel;   // Next free slot, wrapping
    logic       match;

    ////////////////////////////////////////////////////////////////////////////
    // Locks and selection search

    // Hints lock the lowest slots first
    always_comb begin
        for (int i = 0; i < NS; i++) begin
            hint_mask[i] = hint_active && (i < hint_level);
        end
    end

    assign locked = hint_mask | {NS{correct}};

    always_comb begin
        left_sel  = sel;
        right_sel = sel;
        skip_sel  = sel;
        for (int i = 0; i < NS; i++) begin
            if (i < sel && !locked[i]) left_sel = slot_t'(i);  // Last hit is nearest
        end
        for (int i = NS - 1; i >= 0; i--) begin
            if (i > sel && !locked[i]) right_sel = slot_t'(i);
        end
        for (int k = NS - 1; k > 0; k--) begin
            if (!locked[(int'(sel) + k) % NS]) skip_sel = slot_t'((int'(sel) + k) % NS);
        end
    end

    always_comb begin
        match = 1'b1;
        for (int i = 0; i < NS; i++) begin
            if (word[i] != target[i]) match = 1'b0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Word state

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NS; i++) word[i] <= '0;
            sel     <= '0;
            correct <= 1'b0;
        end else if (new_round) begin
            for (int i = 0; i < NS; i++) word[i] <= '0;  // Back to AAAAA
            sel     <= '0;
            correct <= 1'b0;
        end else begin
            for (int i = 0; i < NS; i++) begin
                if (locked[i]) begin
                    word[i] <= target[i];
                end else if (i == sel && cmd == CMD_UP) begin
                    word[i] <= (word[i] == LAST) ? '0 : word[i] + 1'b1;
                end else if (i == sel && cmd == CMD_DOWN) begin
                    word[i] <= (word[i] == '0) ? LAST : word[i] - 1'b1;
                end
            end

            // Locked slot under the cursor pushes it on
            if (locked[sel] && !correct)             sel <= skip_sel;
            else if (cmd == CMD_LEFT && !correct)    sel <= left_sel;
            else if (cmd == CMD_RIGHT && !correct)   sel <= right_sel;

            if (cmd == CMD_CHECK && !correct) correct <= match;
        end
    end

    a_sel_range: assert property (@(posedge clk) disable iff (!rst_n)
        sel < NS);

    for (genvar i = 0; i < NS; i++) begin : g_letter_chk
        a_letter_range: assert property (@(posedge clk) disable iff (!rst_n)
            word[i] <= LAST);
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+hw
hw/letter_cycler_pkg.sv
hw/button_decoder.sv
hw/word_editor.sv
hw/glyph_rom.sv
hw/oled_renderer.sv
hw/letter_cycler.sv
verif/letter_cycler_tb.sv

// ==== verif/letter_cycler_tb.sv ====
`default_nettype none
`include "letter_cycler_cfg.svh"

module letter_cycler_tb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int ROWS        = 8;
    localparam int NPIX        = 3;     // Pixel checks per row
    localparam int MAX_PRESSES = 20;
    localparam int CYCLE_LIMIT = ROWS * MAX_PRESSES * 12 + 600;

    logic        clk = 1'b0;
    logic        rst_n;
    logic        btn_up;
    logic        btn_down;
    logic        btn_left;
    logic        btn_right;
    logic        btn_center;
    logic        new_round;
    logic [12:0] pixel_idx;
    logic [4:0]  target [`LC_NUM_SLOTS];
    logic [2:0]  hint_level;
    logic        hint_active;
    logic [15:0] oled_data;
    logic        word_correct;

    int seed   = 46588;
    int cycles = 0;
    int checks = 0;
    int errors = 0;

    // Row table with pixel entries packed as {x, y, colour}
    logic [39:0]     tab_target [ROWS];
    logic [2:0]      tab_hint   [ROWS];
    logic            tab_active [ROWS];
    logic [8*24-1:0] tab_seq    [ROWS];   // One press code per byte
    logic            tab_ok     [ROWS];
    logic [31:0]     tab_pix    [ROWS][NPIX];

    letter_cycler #(
        .DEBOUNCE_CYCLES (4)
    ) i_letter_cycler (
        .clk          (clk),
        .rst_n        (rst_n),
        .btn_up       (btn_up),
        .btn_down     (btn_down),
        .btn_left     (btn_left),
        .btn_right    (btn_right),
        .btn_center   (btn_center),
        .new_round    (new_round),
        .pixel_idx    (pixel_idx),
        .target       (target),
        .hint_level   (hint_level),
        .hint_active  (hint_active),
        .oled_data    (oled_data),
        .word_correct (word_correct)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("CHECKS FAILED");
            $finish;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Table

    task automatic add_row(input int r, input logic [39:0] t, input logic [2:0] h,
                           input logic a, input logic [8*24-1:0] s, input logic ok,
                           input logic [31:0] p0, input logic [31:0] p1,
                           input logic [31:0] p2);
        tab_target[r] = t;
        tab_hint[r]   = h;
        tab_active[r] = a;
        tab_seq[r]    = s;
        tab_ok[r]     = ok;
        tab_pix[r][0] = p0;
        tab_pix[r][1] = p1;
        tab_pix[r][2] = p2;
    endtask

    task automatic load_table();
        add_row(0, "AAAAA", 3'd0, 1'b0, "", 1'b0,             // State after reset
                {8'd3, 8'd3, `LC_COL_BLUE}, {8'd48, 8'd10, `LC_COL_BLACK},
                {8'd17, 8'd39, `LC_COL_WHITE});
        add_row(1, "BCAAB", 3'd0, 1'b0, "HRUURRRUC", 1'b1,
                {8'd18, 8'd27, `LC_COL_GREEN}, {8'd69, 8'd39, `LC_COL_BLACK},
                {8'd3, 8'd3, `LC_COL_BLUE});
        add_row(2, "ZAAAB", 3'd0, 1'b0, "DRRRRUC", 1'b1,      // Down from A wraps to Z
                {8'd18, 8'd27, `LC_COL_GREEN}, {8'd17, 8'd27, `LC_COL_BLACK},
                {8'd69, 8'd39, `LC_COL_BLACK});
        add_row(3, "BBBBB", 3'd0, 1'b0, "UK", 1'b0,
                {8'd17, 8'd39, `LC_COL_RED}, {8'd18, 8'd27, `LC_COL_RED},
                {8'd48, 8'd10, `LC_COL_BLACK});
        add_row(4, "BACAB", 3'd0, 1'b0, "*", 1'b1,            // Slots visited in random order
                {8'd3, 8'd3, `LC_COL_BLUE}, {8'd18, 8'd27, `LC_COL_GREEN},
                {8'd92, 8'd60, `LC_COL_BLUE});
        add_row(5, "CABAB", 3'd2, 1'b1, "L", 1'b0,
                {8'd43, 8'd39, `LC_COL_WHITE}, {8'd17, 8'd39, `LC_COL_BLACK},
                {8'd19, 8'd27, `LC_COL_YELLOW});
        add_row(6, "CABAB", 3'd2, 1'b1, "URRUC", 1'b1,
                {8'd19, 8'd27, `LC_COL_GREEN}, {8'd69, 8'd39, `LC_COL_BLACK},
                {8'd3, 8'd3, `LC_COL_BLUE});
        add_row(7, "AAAAA", 3'd0, 1'b0, "", 1'b0,             // Fresh round after a win
                {8'd17, 8'd39, `LC_COL_WHITE}, {8'd48, 8'd10, `LC_COL_BLACK},
                {8'd3, 8'd3, `LC_COL_BLUE});
    endtask

    function automatic int letter_at(input int r, input int s);
        return tab_target[r][8*(4-s) +: 8] - 8'h41;   // ASCII to letter index
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus and checks
    // Every task starts and ends on a rising edge

    // H is a long up press and K keeps the center held
    task automatic set_button(input byte code, input logic v);
        case (code)
            "U", "H": btn_up     <= v;
            "D":      btn_down   <= v;
            "L":      btn_left   <= v;
            "R":      btn_right  <= v;
            "C", "K": btn_center <= v;
            default: begin
                errors++;
                $display("Table problem: unknown press code %c", code);
            end
        endcase
    endtask

    task automatic press(input byte code);
        int held;
        held = (code == "H") ? 20 : 2;
        set_button(code, 1'b1);
        if (code == "K") begin
            repeat (4) @(posedge clk);   // Stays held through the pixel checks
        end else begin
            repeat (held) @(posedge clk);
            set_button(code, 1'b0);
            repeat (8) @(posedge clk);
        end
    endtask

    task automatic spell_random(input int r);
        int order [5];
        int cur;
        int j;
        int tmp;
        for (int i = 0; i < 5; i++) order[i] = i;
        for (int i = 4; i > 0; i--) begin
            j        = $unsigned($random(seed)) % (i + 1);
            tmp      = order[i];
            order[i] = order[j];
            order[j] = tmp;
        end
        cur = 0;
        for (int k = 0; k < 5; k++) begin
            while (cur < order[k]) begin
                press("R");
                cur++;
            end
            while (cur > order[k]) begin
                press("L");
                cur--;
            end
            repeat (letter_at(r, order[k])) press("U");
        end
        press("C");
    endtask

    task automatic start_round(input int r);
        for (int s = 0; s < 5; s++) target[s] <= 5'(letter_at(r, s));
        hint_level  <= tab_hint[r];
        hint_active <= tab_active[r];
        new_round   <= 1'b1;
        @(posedge clk);
        new_round <= 1'b0;
        repeat (3) @(posedge clk);   // Cursor leaves locked slots
    endtask

    task automatic run_sequence(input int r);
        byte code;
        for (int i = 23; i >= 0; i--) begin
            code = tab_seq[r][8*i +: 8];
            if (code == "*") spell_random(r);   // Star spells in random slot order
            else if (code != 8'h00) press(code);
        end
    endtask

    task automatic check_correct(input int r);
        @(negedge clk);
        checks++;
        assert (word_correct === tab_ok[r]) else begin
            errors++;
            $display("ERROR %0t: word_correct is %b, expected %b", $time, word_correct,
                     tab_ok[r]);
        end
        @(posedge clk);
    endtask

    task automatic check_pixel(input logic [31:0] pix);
        int x;
        int y;
        x = pix[31:24];
        y = pix[23:16];
        pixel_idx <= 13'(y * `LC_OLED_W + x);
        @(posedge clk);
        @(negedge clk);
        checks++;
        assert (oled_data === pix[15:0]) else begin
            errors++;
            $display("ERROR %0t: pixel (%0d,%0d) is %h, expected %h", $time, x, y,
                     oled_data, pix[15:0]);
        end
        @(posedge clk);
    endtask

    initial begin
        int row_errors;
        rst_n       = 1'b0;
        btn_up      = 1'b0;
        btn_down    = 1'b0;
        btn_left    = 1'b0;
        btn_right   = 1'b0;
        btn_center  = 1'b0;
        new_round   = 1'b0;
        pixel_idx   = '0;
        hint_level  = '0;
        hint_active = 1'b0;
        for (int s = 0; s < 5; s++) target[s] = '0;
        load_table();
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);

        for (int r = 0; r < ROWS; r++) begin
            row_errors = errors;
            start_round(r);
            run_sequence(r);
            check_correct(r);
            for (int p = 0; p < NPIX; p++) check_pixel(tab_pix[r][p]);
            btn_center <= 1'b0;
            $display("Test %0d target %s: %s", r, tab_target[r],
                     (errors == row_errors) ? "passed" : "failed");
        end

        $display("Summary: %0d tests, %0d checks, %0d errors", ROWS, checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
